//--- verilog/prefix_alu_pkg.sv
// Prefix ALU shared definitions: operand width, opcodes and carry-in source
`default_nettype none

package prefix_alu_pkg;

	// Operand and result width, tied to the hand-wired prefix tree
	localparam int data_width = 14;

	// Opcodes
	// Subtract forms invert b and treat the carry as not-borrow
	typedef enum logic [1:0] {
		op_add = 2'b00,
		op_adc = 2'b01,
		op_sub = 2'b10,
		op_sbc = 2'b11
	} alu_op_t;

	// Carry-in source for the result stage
	// cin_fixed takes the constant decoded from the opcode
	// cin_flag takes the stored carry flag for chained operations
	typedef enum logic {
		cin_fixed = 1'b0,
		cin_flag  = 1'b1
	} cin_src_t;

endpackage

`default_nettype wire

//--- verilog/ling_prefix_tree.sv
// Ling-style parallel-prefix tree producing sum and carry-out from propagate/generate bits
`timescale 1ns/1ps
`default_nettype none

module ling_prefix_tree (
	input  wire  [14:0] p,
	input  wire  [14:0] g,
	output logic [13:0] sum,
	output logic        cout
);

	// Pseudo-carries (h) and true carries (c) per extended position
	logic [14:1] h;
	logic [14:1] c;

	// Stage 1, spans of two bits
	logic h_1_0;
	logic h_3_2, i_3_2;
	logic h_5_4, i_5_4;
	logic h_7_6, i_7_6;
	logic h_9_8, i_9_8;
	logic h_11_10, i_11_10;
	logic h_13_12, i_13_12;

	// Stage 2, spans of four bits
	logic h_3_0;
	logic h_5_2, i_5_2;
	logic h_7_4, i_7_4;
	logic h_9_6, i_9_6;
	logic h_11_8, i_11_8;
	logic h_13_10, i_13_10;

	// Stage 3, spans of eight bits
	logic h_5_0;
	logic h_7_0;
	logic h_9_2, i_9_2;
	logic h_11_4, i_11_4;
	logic h_13_6, i_13_6;

	// Stage 4, remaining odd positions
	logic h_9_0;
	logic h_11_0;
	logic h_13_0;

	// Extra grey stage, even positions
	logic h_2_0;
	logic h_4_0;
	logic h_6_0;
	logic h_8_0;
	logic h_10_0;
	logic h_12_0;

	// Stage 1
	// p[0] is tied high, so the first node reduces to an OR
	assign h_1_0   = g[1] | (p[0] & g[0]);
	assign h_3_2   = g[3] | g[2];
	assign i_3_2   = p[2] & p[1];
	assign h_5_4   = g[5] | g[4];
	assign i_5_4   = p[4] & p[3];
	assign h_7_6   = g[7] | g[6];
	assign i_7_6   = p[6] & p[5];
	assign h_9_8   = g[9] | g[8];
	assign i_9_8   = p[8] & p[7];
	assign h_11_10 = g[11] | g[10];
	assign i_11_10 = p[10] & p[9];
	assign h_13_12 = g[13] | g[12];
	assign i_13_12 = p[12] & p[11];

	// Stage 2
	assign h_3_0   = h_3_2 | (i_3_2 & h_1_0);
	assign h_5_2   = h_5_4 | (i_5_4 & h_3_2);
	assign i_5_2   = i_5_4 & i_3_2;
	assign h_7_4   = h_7_6 | (i_7_6 & h_5_4);
	assign i_7_4   = i_7_6 & i_5_4;
	assign h_9_6   = h_9_8 | (i_9_8 & h_7_6);
	assign i_9_6   = i_9_8 & i_7_6;
	assign h_11_8  = h_11_10 | (i_11_10 & h_9_8);
	assign i_11_8  = i_11_10 & i_9_8;
	assign h_13_10 = h_13_12 | (i_13_12 & h_11_10);
	assign i_13_10 = i_13_12 & i_11_10;

	// Stage 3
	assign h_5_0  = h_5_2 | (i_5_2 & h_1_0);
	assign h_7_0  = h_7_4 | (i_7_4 & h_3_0);
	assign h_9_2  = h_9_6 | (i_9_6 & h_5_2);
	assign i_9_2  = i_9_6 & i_5_2;
	assign h_11_4 = h_11_8 | (i_11_8 & h_7_4);
	assign i_11_4 = i_11_8 & i_7_4;
	assign h_13_6 = h_13_10 | (i_13_10 & h_9_6);
	assign i_13_6 = i_13_10 & i_9_6;

	// Stage 4
	assign h_9_0  = h_9_2 | (i_9_2 & h_1_0);
	assign h_11_0 = h_11_4 | (i_11_4 & h_3_0);
	assign h_13_0 = h_13_6 | (i_13_6 & h_5_0);

	// Even positions hang off the odd neighbour below
	assign h_2_0  = g[2] | (p[1] & h_1_0);
	assign h_4_0  = g[4] | (p[3] & h_3_0);
	assign h_6_0  = g[6] | (p[5] & h_5_0);
	assign h_8_0  = g[8] | (p[7] & h_7_0);
	assign h_10_0 = g[10] | (p[9] & h_9_0);
	assign h_12_0 = g[12] | (p[11] & h_11_0);

	// Collect pseudo-carries
	assign h[13:1] = {h_13_0, h_12_0, h_11_0, h_10_0, h_9_0, h_8_0, h_7_0,
		h_6_0, h_5_0, h_4_0, h_3_0, h_2_0, h_1_0};

	// True carry into position k+1 is p[k] & h[k]
	assign c[1]     = g[0];
	assign c[14:2]  = p[13:1] & h[13:1];

	// Top pseudo-carry folds in the last generate
	assign h[14] = g[14] | c[14];

	// Post-computation
	assign sum  = (p[14:1] ^ h) | (g[14:1] & c);
	assign cout = p[14] & h[14];

endmodule

`default_nettype wire

//--- verilog/prefix_adder.sv
// 14-bit Ling prefix adder with carry-in, pre-computation around the prefix tree
`timescale 1ns/1ps
`default_nettype none

module prefix_adder (
	input  wire  [13:0] a,
	input  wire  [13:0] b,
	input  wire         cin,
	output logic [13:0] sum,
	output logic        cout
);

	// Extended vectors, position 0 carries the carry-in
	logic [14:0] p;
	logic [14:0] g;

	// Ling uses OR for propagate
	assign p = {a | b, 1'b1};
	assign g = {a & b, cin};

	ling_prefix_tree u_tree (
		.p    (p),
		.g    (g),
		.sum  (sum),
		.cout (cout)
	);

endmodule

`default_nettype wire

//--- verilog/operand_stage.sv
// Operand stage: decodes the opcode, conditions b and registers the operation
`timescale 1ns/1ps
`default_nettype none

module operand_stage (
	input  wire                                  clk,
	input  wire                                  rst_n,
	input  wire                                  in_valid,
	input  wire prefix_alu_pkg::alu_op_t         op,
	input  wire  [prefix_alu_pkg::data_width-1:0] a,
	input  wire  [prefix_alu_pkg::data_width-1:0] b,
	output logic                                 s1_valid,
	output logic [prefix_alu_pkg::data_width-1:0] s1_a,
	output logic [prefix_alu_pkg::data_width-1:0] s1_b,
	output prefix_alu_pkg::cin_src_t             s1_cin_src,
	output logic                                 s1_cin_fixed
);

	// Decoded controls
	logic                     invert_b;
	prefix_alu_pkg::cin_src_t cin_src_d;
	logic                     cin_fixed_d;

	always_comb begin
		invert_b    = 1'b0;
		cin_src_d   = prefix_alu_pkg::cin_fixed;
		cin_fixed_d = 1'b0;
		case (op)
			prefix_alu_pkg::op_adc: begin
				cin_src_d = prefix_alu_pkg::cin_flag;
			end
			prefix_alu_pkg::op_sub: begin
				// a + ~b + 1
				invert_b    = 1'b1;
				cin_fixed_d = 1'b1;
			end
			prefix_alu_pkg::op_sbc: begin
				// Stored carry acts as not-borrow
				invert_b  = 1'b1;
				cin_src_d = prefix_alu_pkg::cin_flag;
			end
			default: begin
				invert_b = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			s1_valid <= 1'b0;
		end else begin
			s1_valid <= in_valid;
		end
	end

	// Operation payload, loaded only on a strobe
	always_ff @(posedge clk) begin
		if (in_valid) begin
			s1_a         <= a;
			s1_b         <= invert_b ? ~b : b;
			s1_cin_src   <= cin_src_d;
			s1_cin_fixed <= cin_fixed_d;
		end
	end

	// Opcode must be known whenever an operation is issued
	a_op_known: assert property (@(posedge clk) disable iff (!rst_n)
		in_valid |-> !$isunknown(op));

endmodule

`default_nettype wire

//--- verilog/result_stage.sv
// Result stage: carry-in select, prefix add, flags, carry flag and output registers
`timescale 1ns/1ps
`default_nettype none

module result_stage (
	input  wire                                  clk,
	input  wire                                  rst_n,
	input  wire                                  s1_valid,
	input  wire  [prefix_alu_pkg::data_width-1:0] s1_a,
	input  wire  [prefix_alu_pkg::data_width-1:0] s1_b,
	input  wire prefix_alu_pkg::cin_src_t        s1_cin_src,
	input  wire                                  s1_cin_fixed,
	output logic                                 out_valid,
	output logic [prefix_alu_pkg::data_width-1:0] result,
	output logic                                 carry,
	output logic                                 overflow,
	output logic                                 zero
);

	logic                                 carry_flag;
	logic                                 cin;
	logic [prefix_alu_pkg::data_width-1:0] sum;
	logic                                 cout;
	logic                                 overflow_d;
	logic                                 zero_d;

	// Chained ops read the carry left by the previous operation
	assign cin = (s1_cin_src == prefix_alu_pkg::cin_flag) ? carry_flag : s1_cin_fixed;

	prefix_adder u_adder (
		.a    (s1_a),
		.b    (s1_b),
		.cin  (cin),
		.sum  (sum),
		.cout (cout)
	);

	// Signed overflow: like-signed inputs, sum of the other sign
	assign overflow_d = (s1_a[prefix_alu_pkg::data_width-1] == s1_b[prefix_alu_pkg::data_width-1])
		&& (sum[prefix_alu_pkg::data_width-1] != s1_a[prefix_alu_pkg::data_width-1]);
	assign zero_d = (sum == '0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= s1_valid;
		end
	end

	// Results and flags hold between operations
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			carry_flag <= 1'b0;
			result     <= '0;
			overflow   <= 1'b0;
			zero       <= 1'b0;
		end else if (s1_valid) begin
			carry_flag <= cout;
			result     <= sum;
			overflow   <= overflow_d;
			zero       <= zero_d;
		end
	end

	// The carry output is the stored flag itself
	assign carry = carry_flag;

	// One output strobe per operation, one cycle later
	a_valid_latency: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid == $past(s1_valid));

	// Carry only moves after an accepted operation
	a_carry_hold: assert property (@(posedge clk) disable iff (!rst_n)
		!$stable(carry) |-> $past(s1_valid));

endmodule

`default_nettype wire

//--- verilog/prefix_alu.sv
// Prefix ALU top: two-stage add/subtract unit with carry, overflow and zero flags
`timescale 1ns/1ps
`default_nettype none

module prefix_alu (
	input  wire                                  clk,
	input  wire                                  rst_n,
	input  wire                                  in_valid,
	input  wire prefix_alu_pkg::alu_op_t         op,
	input  wire  [prefix_alu_pkg::data_width-1:0] a,
	input  wire  [prefix_alu_pkg::data_width-1:0] b,
	output logic                                 out_valid,
	output logic [prefix_alu_pkg::data_width-1:0] result,
	output logic                                 carry,
	output logic                                 overflow,
	output logic                                 zero
);

	// Operand stage to result stage
	logic                                 s1_valid;
	logic [prefix_alu_pkg::data_width-1:0] s1_a;
	logic [prefix_alu_pkg::data_width-1:0] s1_b;
	prefix_alu_pkg::cin_src_t             s1_cin_src;
	logic                                 s1_cin_fixed;

	operand_stage u_operand_stage (
		.clk          (clk),
		.rst_n        (rst_n),
		.in_valid     (in_valid),
		.op           (op),
		.a            (a),
		.b            (b),
		.s1_valid     (s1_valid),
		.s1_a         (s1_a),
		.s1_b         (s1_b),
		.s1_cin_src   (s1_cin_src),
		.s1_cin_fixed (s1_cin_fixed)
	);

	result_stage u_result_stage (
		.clk          (clk),
		.rst_n        (rst_n),
		.s1_valid     (s1_valid),
		.s1_a         (s1_a),
		.s1_b         (s1_b),
		.s1_cin_src   (s1_cin_src),
		.s1_cin_fixed (s1_cin_fixed),
		.out_valid    (out_valid),
		.result       (result),
		.carry        (carry),
		.overflow     (overflow),
		.zero         (zero)
	);

endmodule

`default_nettype wire

//--- verification/tb_clock_gen.sv
// Testbench clock and reset generator: 40 ns clock, reset held low over two rising edges
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic clk,
	output logic rst_n
);

	// 40 ns period
	initial begin
		clk = 1'b0;
		forever begin
			#20 clk = ~clk;
		end
	end

	// Released on a falling edge, clear of the sampling points
	initial begin
		rst_n = 1'b0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule

`default_nettype wire

//--- verification/prefix_alu_tb.sv
// Prefix ALU testbench: directed and seeded random add/subtract tests against a 15-bit model
`timescale 1ns/1ps
`default_nettype none

module prefix_alu_tb;

	localparam int timeout_cycles = 10;

	logic                                  clk;
	logic                                  rst_n;
	logic                                  in_valid;
	prefix_alu_pkg::alu_op_t               op;
	logic [prefix_alu_pkg::data_width-1:0] a;
	logic [prefix_alu_pkg::data_width-1:0] b;
	logic                                  out_valid;
	logic [prefix_alu_pkg::data_width-1:0] result;
	logic                                  carry;
	logic                                  overflow;
	logic                                  zero;

	// Scoreboard of expected {carry, overflow, zero, result} words and their due cycles
	logic [16:0] exp_q[$];
	int          due_q[$];
	logic [13:0] got_q[$];
	int          cycle;
	integer      seed;
	logic        model_carry;
	logic [13:0] last_result;
	logic        last_carry;
	logic        last_ovf;
	logic        last_zero;

	tb_clock_gen u_clock_gen (
		.clk   (clk),
		.rst_n (rst_n)
	);

	prefix_alu dut0 (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.op        (op),
		.a         (a),
		.b         (b),
		.out_valid (out_valid),
		.result    (result),
		.carry     (carry),
		.overflow  (overflow),
		.zero      (zero)
	);

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("Fail at %0t ns: %s got 0x%0h, expected 0x%0h", $time, name, got, exp);
			$display("sim failed");
			$fatal(1);
		end
	endtask

	task automatic timeout_fail(input string what);
		$display("%s after %0d cycles at %0t ns", what, timeout_cycles, $time);
		$display("sim failed");
		$fatal(1);
	endtask

	// Expected response from 15-bit arithmetic with b inverted for the subtract forms
	task automatic predict(input prefix_alu_pkg::alu_op_t op_i, input logic [13:0] a_i,
		input logic [13:0] b_i);
		logic [13:0] b_eff;
		logic        cin_v;
		logic [14:0] full;
		logic        ovf;
		int          sa;
		int          sb;
		int          s_sum;
		case (op_i)
			prefix_alu_pkg::op_add: begin
				b_eff = b_i;
				cin_v = 1'b0;
			end
			prefix_alu_pkg::op_adc: begin
				b_eff = b_i;
				cin_v = model_carry;
			end
			prefix_alu_pkg::op_sub: begin
				b_eff = ~b_i;
				cin_v = 1'b1;
			end
			default: begin
				b_eff = ~b_i;
				cin_v = model_carry;
			end
		endcase
		full = {1'b0, a_i} + {1'b0, b_eff} + cin_v;
		// Signed sum outside the 14-bit two's complement range
		sa = $signed(a_i);
		sb = $signed(b_eff);
		s_sum = sa + sb + cin_v;
		ovf = (s_sum > 8191) || (s_sum < -8192);
		model_carry = full[14];
		exp_q.push_back({full[14], ovf, (full[13:0] == 14'd0), full[13:0]});
	endtask

	// Advance one clock and check out_valid timing and the output registers
	task automatic step();
		logic [16:0] exp_word;
		logic        due;
		@(posedge clk);
		#2;
		cycle = cycle + 1;
		in_valid = 1'b0;
		due = (due_q.size() > 0) && (due_q[0] == cycle);
		check("out_valid", out_valid, due);
		if (out_valid) begin
			exp_word = exp_q.pop_front();
			void'(due_q.pop_front());
			check("result", result, exp_word[13:0]);
			check("carry", carry, exp_word[16]);
			check("overflow", overflow, exp_word[15]);
			check("zero", zero, exp_word[14]);
			got_q.push_back(result);
			last_result = result;
			last_carry = carry;
			last_ovf = overflow;
			last_zero = zero;
		end else begin
			// Nothing moves in an idle cycle
			check("result", result, last_result);
			check("carry", carry, last_carry);
			check("overflow", overflow, last_ovf);
			check("zero", zero, last_zero);
		end
	endtask

	task automatic issue(input prefix_alu_pkg::alu_op_t op_i, input logic [13:0] a_i,
		input logic [13:0] b_i);
		in_valid = 1'b1;
		op = op_i;
		a = a_i;
		b = b_i;
		predict(op_i, a_i, b_i);
		due_q.push_back(cycle + 2);
		step();
	endtask

	task automatic drain();
		int waited;
		int pending;
		waited = 0;
		while (exp_q.size() > 0) begin
			if (waited >= timeout_cycles) begin
				timeout_fail("out_valid never arrived");
			end
			pending = exp_q.size();
			step();
			if (exp_q.size() < pending) begin
				waited = 0;
			end else begin
				waited = waited + 1;
			end
		end
	endtask

	task automatic reset_values();
		int waited;
		// First clock edge still inside reset
		@(posedge clk);
		#2;
		check("out_valid", out_valid, 1'b0);
		check("carry", carry, 1'b0);
		check("overflow", overflow, 1'b0);
		check("zero", zero, 1'b0);
		waited = 0;
		while (!rst_n) begin
			if (waited >= timeout_cycles) begin
				timeout_fail("reset was never released");
			end
			@(posedge clk);
			#2;
			waited = waited + 1;
		end
		cycle = 0;
		last_result = '0;
		last_carry = 1'b0;
		last_ovf = 1'b0;
		last_zero = 1'b0;
		model_carry = 1'b0;
		check("result", result, 14'd0);
		repeat (3) step();
	endtask

	// Carry born at bit i has to travel to the top
	task automatic carry_ripple();
		logic [13:0] bit_i;
		for (int i = 0; i < 14; i++) begin
			bit_i = 14'd1 << i;
			issue(prefix_alu_pkg::op_add, 14'h3FFF, bit_i);
			issue(prefix_alu_pkg::op_add, bit_i, 14'h3FFF);
			issue(prefix_alu_pkg::op_sub, 14'h0000, bit_i);
			issue(prefix_alu_pkg::op_sub, bit_i, 14'h0000);
		end
		drain();
	endtask

	task automatic random_ops();
		logic [31:0]             r;
		prefix_alu_pkg::alu_op_t op_i;
		for (int n = 0; n < 200; n++) begin
			r = $random(seed);
			op_i = r[0] ? prefix_alu_pkg::op_sub : prefix_alu_pkg::op_add;
			issue(op_i, $random(seed), $random(seed));
		end
		drain();
	endtask

	task automatic add_28(input logic [27:0] x, input logic [27:0] y);
		logic [28:0] full;
		got_q.delete();
		issue(prefix_alu_pkg::op_add, x[13:0], y[13:0]);
		issue(prefix_alu_pkg::op_adc, x[27:14], y[27:14]);
		drain();
		full = {1'b0, x} + {1'b0, y};
		check("chained add result", {got_q[1], got_q[0]}, full[27:0]);
		check("chained add carry", last_carry, full[28]);
	endtask

	task automatic sub_28(input logic [27:0] x, input logic [27:0] y);
		logic [28:0] full;
		got_q.delete();
		issue(prefix_alu_pkg::op_sub, x[13:0], y[13:0]);
		issue(prefix_alu_pkg::op_sbc, x[27:14], y[27:14]);
		drain();
		// Carry out is not-borrow
		full = {1'b0, x} + {1'b0, ~y} + 29'd1;
		check("chained sub result", {got_q[1], got_q[0]}, full[27:0]);
		check("chained sub carry", last_carry, full[28]);
	endtask

	task automatic wide_arith();
		add_28(28'h0003FFF, 28'h0000001);
		add_28(28'hFFFFFFF, 28'h0000001);
		sub_28(28'h0004000, 28'h0000001);
		sub_28(28'h0000000, 28'h0000001);
		for (int n = 0; n < 8; n++) begin
			add_28($random(seed), $random(seed));
			sub_28($random(seed), $random(seed));
		end
	endtask

	task automatic flag_corners();
		logic [13:0] v;
		issue(prefix_alu_pkg::op_add, 14'h1FFF, 14'h0001);
		drain();
		check("overflow on max positive + 1", last_ovf, 1'b1);
		check("result on max positive + 1", last_result, 14'h2000);
		issue(prefix_alu_pkg::op_sub, 14'h2000, 14'h0001);
		drain();
		check("overflow on min negative - 1", last_ovf, 1'b1);
		check("result on min negative - 1", last_result, 14'h1FFF);
		v = $random(seed);
		issue(prefix_alu_pkg::op_sub, v, v);
		drain();
		check("zero on a - a", last_zero, 1'b1);
		check("carry on a - a", last_carry, 1'b1);
		// Borrow from 5 - 7 takes one more off 10 - 3
		issue(prefix_alu_pkg::op_sub, 14'd5, 14'd7);
		issue(prefix_alu_pkg::op_sbc, 14'd10, 14'd3);
		drain();
		check("sbc after borrow", last_result, 14'd6);
		issue(prefix_alu_pkg::op_sub, 14'd7, 14'd5);
		issue(prefix_alu_pkg::op_sbc, 14'd10, 14'd3);
		drain();
		check("sbc without borrow", last_result, 14'd7);
	endtask

	// step() checks out_valid every cycle and the carry hold while idle
	task automatic idle_gaps();
		logic [31:0] r;
		int          gap;
		for (int n = 0; n < 24; n++) begin
			r = $random(seed);
			issue(prefix_alu_pkg::alu_op_t'(r[1:0]), $random(seed), $random(seed));
			gap = 1 + r[3:2];
			repeat (gap) step();
		end
		drain();
	endtask

	initial begin
		in_valid = 1'b0;
		op = prefix_alu_pkg::op_add;
		a = '0;
		b = '0;
		seed = 76;
		cycle = 0;
		model_carry = 1'b0;
		last_result = '0;
		last_carry = 1'b0;
		last_ovf = 1'b0;
		last_zero = 1'b0;
		reset_values();
		carry_ripple();
		random_ops();
		wide_arith();
		flag_corners();
		idle_gaps();
		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- prefix_alu.f
verilog/prefix_alu_pkg.sv
verilog/ling_prefix_tree.sv
verilog/prefix_adder.sv
verilog/operand_stage.sv
verilog/result_stage.sv
verilog/prefix_alu.sv
verification/tb_clock_gen.sv
verification/prefix_alu_tb.sv
